// ==== compile.f ====
src/cpu_pkg.sv
src/micro_rom.sv
src/micro_sequencer.sv
src/addr_gen.sv
src/alu_regs.sv
src/cpu_core.sv
sim/mem_model.sv
sim/tb_cpu_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds tb_cpu_core with Verilator, runs it and scans the log for failure
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir build.log "$LOG"

verilator --binary --timing --assert -f compile.f --top-module tb_cpu_core \
    -Mdir obj_dir -o tb_cpu_core > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_cpu_core > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    exit 1
fi
exit 0

// ==== sim/mem_model.sv ====
// Synchronous 64 KiB memory with one-cycle read latency that the testbench preloads
`timescale 1ns/1ps

module mem_model (
    input  logic        clk,
    input  logic [15:0] addr,
    input  logic        we,
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata = 8'h00   // Known value before the first read
);

    logic [7:0] mem [0:65535];  // Written directly by the testbench

    // Background pattern from both address bytes
    initial begin
        int i;
        for (i = 0; i < 65536; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
        end
    end

    always @(posedge clk) begin
        rdata <= #2 mem[addr];   // Data one cycle after the address with a small hold
        if (we) begin
            mem[addr] = wdata;   // Store lands at the end of the write cycle
        end
    end

endmodule

// ==== sim/tb_cpu_core.sv ====
// Testbench for cpu_core that assembles a program into memory and checks the bus traffic
`timescale 1ns/1ps

module tb_cpu_core;

    localparam logic [15:0] START_PC = 16'h0200;
    localparam int          MAX_OPS  = 64;

    logic        clk;
    logic        reset;
    logic [7:0]  db_in;
    logic [15:0] ab;
    logic [7:0]  do_out;
    logic        we;
    logic        sync;

    int          seed = 32'h3db8;
    logic [15:0] asm_pc;                    // Assembly location
    logic [7:0]  a_m;                       // Reference A
    logic [7:0]  x_m;                       // Reference X
    logic        c_m;                       // Reference carry
    logic [7:0]  zp_shadow [0:255];         // Expected zero page
    logic [15:0] fetch_addr [0:MAX_OPS-1];  // Opcode addresses in execution order
    int          fetch_test [0:MAX_OPS-1];
    logic [15:0] exp_waddr [0:MAX_OPS-1];
    logic [7:0]  exp_wdata [0:MAX_OPS-1];
    int          test_start [0:6];          // Entry 6 is the closing self-jump
    int          write_end [0:5];
    int          test_errors [0:5];
    string       test_names [0:5];
    int          n_fetch = 0;
    int          n_write = 0;
    int          fetch_idx = 0;
    int          write_idx = 0;
    int          cur_test = 0;
    int          exec_test = 0;             // Test of the instruction now running
    int          errors = 0;
    int          passed = 0;
    logic        asm_done = 1'b0;
    logic [15:0] prev_ab;

    cpu_core #(.RESET_PC(START_PC)) u_cpu_core (
        .clk    (clk),
        .reset  (reset),
        .db_in  (db_in),
        .ab     (ab),
        .do_out (do_out),
        .we     (we),
        .sync   (sync)
    );

    mem_model u_mem (.clk(clk), .addr(ab), .we(we), .wdata(do_out), .rdata(db_in));

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    function automatic logic [7:0] rand_byte();
        int r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic emit(input logic [7:0] b);
        u_mem.mem[asm_pc] = b;
        asm_pc = asm_pc + 16'd1;
    endtask

    task automatic start_instr(input logic [7:0] opcode);
        fetch_addr[n_fetch] = asm_pc;  // Next sync must fetch from here
        fetch_test[n_fetch] = cur_test;
        n_fetch++;
        emit(opcode);
    endtask

    task automatic poke_zp(input logic [7:0] zp, input logic [7:0] v);
        u_mem.mem[{8'h00, zp}] = v;
        zp_shadow[zp] = v;
    endtask

    task automatic expect_write(input logic [7:0] zp, input logic [7:0] v);
        exp_waddr[n_write] = {8'h00, zp};
        exp_wdata[n_write] = v;
        n_write++;
        zp_shadow[zp] = v;
    endtask

    task automatic lda_imm(input logic [7:0] v);
        start_instr(cpu_pkg::LDA_IMM);
        emit(v);
        a_m = v;
    endtask

    task automatic lda_zp(input logic [7:0] zp);
        start_instr(cpu_pkg::LDA_ZP);
        emit(zp);
        a_m = zp_shadow[zp];
    endtask

    task automatic ldx_zp(input logic [7:0] zp);
        start_instr(cpu_pkg::LDX_ZP);
        emit(zp);
        x_m = zp_shadow[zp];
    endtask

    task automatic sta_zp(input logic [7:0] zp);
        start_instr(cpu_pkg::STA_ZP);
        emit(zp);
        expect_write(zp, a_m);
    endtask

    task automatic stx_zp(input logic [7:0] zp);
        start_instr(cpu_pkg::STX_ZP);
        emit(zp);
        expect_write(zp, x_m);
    endtask

    task automatic adc_imm(input logic [7:0] v);
        int sum;
        start_instr(cpu_pkg::ADC_IMM);
        emit(v);
        sum = int'(a_m) + int'(v) + int'(c_m);  // A plus operand plus carry
        c_m = (sum > 255);
        a_m = 8'(sum % 256);
    endtask

    task automatic set_carry(input logic v);
        start_instr(v ? cpu_pkg::SEC : cpu_pkg::CLC);
        c_m = v;
    endtask

    task automatic inx();
        start_instr(cpu_pkg::INX);
        x_m = x_m + 8'd1;
    endtask

    task automatic jmp_abs(input logic [15:0] target);
        start_instr(cpu_pkg::JMP_ABS);
        emit(target[7:0]);
        emit(target[15:8]);
        asm_pc = target;
    endtask

    task automatic open_test(input int t);
        write_end[cur_test] = n_write;
        cur_test = t;
        test_start[t] = n_fetch;
    endtask

    task automatic count_error(input int t);
        test_errors[t]++;
        errors++;
    endtask

    task automatic report_test(input int t);
        if (test_errors[t] == 0) begin
            $display("test %0d %s: passed", t, test_names[t]);
            passed++;
        end else begin
            $display("test %0d %s: %0d check(s) failed", t, test_names[t], test_errors[t]);
        end
    endtask

    // Bus monitor sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            assert (!we && !sync) else begin
                $display("reset: we or sync high while reset is asserted");
                count_error(0);
            end
        end else begin
            if (sync) begin
                if (fetch_idx < n_fetch) begin
                    exec_test = fetch_test[fetch_idx];
                    assert (prev_ab == fetch_addr[fetch_idx]) else begin  // Opcode from last ab
                        $display("ERR %s: fetch expected %h, actual %h", test_names[exec_test],
                                 fetch_addr[fetch_idx], prev_ab);
                        count_error(exec_test);
                    end
                end
                fetch_idx++;
            end
            if (we) begin
                assert (write_idx < n_write) else begin
                    $display("%s: write to %h with no store pending", test_names[exec_test], ab);
                    count_error(exec_test);
                end
                if (write_idx < n_write) begin
                    assert (ab == exp_waddr[write_idx] && do_out == exp_wdata[write_idx]) else begin
                        $display("ERR %s: store expected %h=%h, actual %h=%h",
                                 test_names[exec_test], exp_waddr[write_idx],
                                 exp_wdata[write_idx], ab, do_out);
                        count_error(exec_test);
                    end
                end
                write_idx++;
            end
        end
        prev_ab = ab;
    end

    // Watchdog allows 40 cycles per instruction plus reset
    initial begin
        wait (asm_done);
        repeat (40 * n_fetch + 20) @(posedge clk);
        $display("Timeout: program never reached its closing jump");
        $display("Something failed");
        $finish;
    end

    initial begin
        int t;
        reset = 1'b1;
        a_m = 8'h00;
        x_m = 8'h00;
        c_m = 1'b0;
        test_names[0] = "reset";
        test_names[1] = "lda_imm_sta";
        test_names[2] = "zp_load_store";
        test_names[3] = "adc_chain";
        test_names[4] = "inx_stx";
        test_names[5] = "jmp_nop";
        #1;  // After the memory fill
        asm_pc = START_PC;
        open_test(1);
        lda_imm(rand_byte());
        sta_zp(8'h10);
        open_test(2);
        poke_zp(8'h40, rand_byte());
        poke_zp(8'h41, rand_byte());
        lda_zp(8'h40);
        sta_zp(8'h20);
        ldx_zp(8'h41);
        stx_zp(8'h21);
        sta_zp(8'h22);  // A untouched by the LDX finisher
        open_test(3);
        set_carry(1'b1);
        lda_imm(rand_byte() | 8'h80);
        adc_imm(rand_byte() | 8'h80);  // Always carries out
        adc_imm(rand_byte());
        sta_zp(8'h30);
        set_carry(1'b0);
        lda_imm(rand_byte());
        adc_imm(rand_byte());
        sta_zp(8'h31);
        open_test(4);
        poke_zp(8'h42, rand_byte() | 8'hf8);
        ldx_zp(8'h42);
        repeat (8) inx();  // Wraps past 0xff
        stx_zp(8'h32);
        open_test(5);
        jmp_abs(16'h0300);
        start_instr(8'h02);  // Undefined opcode
        start_instr(cpu_pkg::NOP);
        lda_imm(rand_byte());
        sta_zp(8'h33);
        write_end[5] = n_write;
        test_start[6] = n_fetch;
        jmp_abs(asm_pc);  // Parks the core
        asm_done = 1'b1;

        repeat (16) @(posedge clk);
        #2 reset = 1'b0;
        @(negedge clk);
        assert (ab == START_PC) else begin
            $display("ERR reset: first ab expected %h, actual %h", START_PC, ab);
            count_error(0);
        end
        @(negedge clk);
        assert (sync) else begin
            $display("reset: sync did not rise in the cycle after the first fetch");
            count_error(0);
        end
        report_test(0);

        for (t = 1; t <= 5; t++) begin
            while (fetch_idx <= test_start[t + 1]) begin
                @(posedge clk);  // Done once the next test's first opcode is fetched
            end
            assert (write_idx == write_end[t]) else begin
                $display("ERR %s: writes expected %0d, actual %0d", test_names[t],
                         write_end[t], write_idx);
                count_error(t);
            end
            report_test(t);
        end

        $display("summary: 6 tests, %0d passed, %0d failed, %0d failed checks",
                 passed, 6 - passed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== src/addr_gen.sv ====
// Address generator: program counter, held bus address and jump low-byte latch
`timescale 1ns/1ps

module addr_gen #(
    parameter logic [15:0] RESET_PC = 16'h0200
) (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::ab_mode_e  ab_mode,
    input  logic [7:0]         db_in,
    output logic [15:0]        ab
);

    logic [15:0] pc;    // Next byte to fetch
    logic [15:0] ab_q;  // Address of the previous cycle
    logic [7:0]  lo;    // Low half of JMP target

    // Bus address follows the current micro-word
    always_comb begin
        case (ab_mode)
            cpu_pkg::AB_ZP:   ab = {8'h00, db_in};  // Zero-page operand just read
            cpu_pkg::AB_JUMP: ab = {db_in, lo};     // High byte arrives now
            cpu_pkg::AB_HOLD: ab = ab_q;
            default:          ab = pc;              // AB_PC and AB_LO_LATCH
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc   <= RESET_PC;
            ab_q <= RESET_PC;
        end else begin
            ab_q <= ab;
            case (ab_mode)
                cpu_pkg::AB_PC:       pc <= pc + 16'd1;
                cpu_pkg::AB_LO_LATCH: pc <= pc + 16'd1;
                cpu_pkg::AB_JUMP:     pc <= {db_in, lo} + 16'd1;  // Target is fetched now
                default:              pc <= pc;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ab_mode == cpu_pkg::AB_LO_LATCH) begin
            lo <= db_in;
        end
    end

endmodule

// ==== src/alu_regs.sv ====
// ALU with A and X registers, C/Z/N flags and the store data register
`timescale 1ns/1ps

module alu_regs (
    input  logic               clk,
    input  logic               reset,
    input  cpu_pkg::alu_op_e   alu_op,
    input  cpu_pkg::reg_sel_e  src,
    input  cpu_pkg::reg_sel_e  dst,
    input  cpu_pkg::flag_op_e  flag_op,
    input  logic [7:0]         db_in,
    output logic [7:0]         do_out
);

    logic [7:0] a;
    logic [7:0] x;
    logic [7:0] res;      // Last ALU result, source for flags and finishers
    logic       res_c;    // Carry from last ALU op
    logic       c;
    logic       z;
    logic       n;
    logic [7:0] src_val;
    logic [7:0] result;
    logic       carry_out;

    always_comb begin
        case (src)
            cpu_pkg::REG_A:  src_val = a;
            cpu_pkg::REG_X:  src_val = x;
            cpu_pkg::REG_DB: src_val = db_in;
            default:         src_val = res;  // Value parked by a shared sequence
        endcase
    end

    always_comb begin
        carry_out = 1'b0;
        case (alu_op)
            cpu_pkg::ALU_ADC: {carry_out, result} = {1'b0, src_val} + {1'b0, db_in} + {8'd0, c};
            cpu_pkg::ALU_INC: result = src_val + 8'd1;
            cpu_pkg::ALU_PASS: result = src_val;
            default:          result = res;
        endcase
    end

    always_ff @(posedge clk) begin
        if (alu_op != cpu_pkg::ALU_NONE) begin
            res   <= result;
            res_c <= carry_out;
            if (dst == cpu_pkg::REG_A) begin
                a <= result;
            end
            if (dst == cpu_pkg::REG_X) begin
                x <= result;
            end
        end
        if (src == cpu_pkg::REG_A || src == cpu_pkg::REG_X) begin
            do_out <= src_val;  // Valid in the following write cycle
        end
    end

    // Flags settle on the last cycle from the last result
    always_ff @(posedge clk) begin
        if (reset) begin
            c <= 1'b0;
            z <= 1'b0;
            n <= 1'b0;
        end else begin
            case (flag_op)
                cpu_pkg::FL_ZN: begin
                    z <= (res == 8'd0);
                    n <= res[7];
                end
                cpu_pkg::FL_CZN: begin
                    c <= res_c;
                    z <= (res == 8'd0);
                    n <= res[7];
                end
                cpu_pkg::FL_CLC: c <= 1'b0;
                cpu_pkg::FL_SEC: c <= 1'b1;
                default: c <= c;
            endcase
        end
    end

endmodule

// ==== src/cpu_core.sv ====
// Core top level: joins sequencer, micro-ROM, address generator and ALU to the memory bus
`timescale 1ns/1ps

module cpu_core #(
    parameter logic [15:0] RESET_PC = 16'h0200
) (
    input  logic        clk,
    input  logic        reset,
    input  logic [7:0]  db_in,   // Read data, one cycle after ab
    output logic [15:0] ab,
    output logic [7:0]  do_out,
    output logic        we,
    output logic        sync     // High while opcode is on db_in
);

    // Loads take 3 cycles, stores 4 since the write cycle cannot also fetch

    cpu_pkg::ucode_t   word;
    logic [8:0]        uaddr;
    cpu_pkg::flag_op_e flag_op;

    // DECODE words carry the flag update in their link field
    assign flag_op = (word.seq == cpu_pkg::DECODE) ?
                     cpu_pkg::flag_op_e'(word.link[2:0]) : cpu_pkg::FL_NONE;

    always_ff @(posedge clk) begin
        if (reset) begin
            we <= 1'b0;
        end else begin
            we <= word.we_next;  // Lines up with held address and do_out
        end
    end

    micro_sequencer u_micro_sequencer (
        .clk   (clk),
        .reset (reset),
        .word  (word),
        .db_in (db_in),
        .uaddr (uaddr),
        .sync  (sync)
    );

    micro_rom u_micro_rom (
        .clk   (clk),
        .uaddr (uaddr),
        .word  (word)
    );

    addr_gen #(.RESET_PC(RESET_PC)) u_addr_gen (
        .clk     (clk),
        .reset   (reset),
        .ab_mode (word.ab_mode),
        .db_in   (db_in),
        .ab      (ab)
    );

    alu_regs u_alu_regs (
        .clk     (clk),
        .reset   (reset),
        .alu_op  (word.alu_op),
        .src     (word.src),
        .dst     (word.dst),
        .flag_op (flag_op),
        .db_in   (db_in),
        .do_out  (do_out)
    );

endmodule

// ==== src/cpu_pkg.sv ====
// Shared types and micro-ROM layout for the microcoded 8-bit core, referenced by scoped name
package cpu_pkg;

    typedef enum logic [1:0] {
        DECODE      = 2'b00,  // Last word, next address is the opcode
        NEXT        = 2'b01,  // Go to SEQ_BASE + link
        FINISH      = 2'b10,  // Go to saved finisher
        SAVE_FINISH = 2'b11   // Go to SEQ_BASE + link, save finisher
    } seq_mode_e;

    typedef enum logic [2:0] {
        AB_PC,        // Bus gets PC, PC increments
        AB_ZP,        // Bus gets {00, data byte}
        AB_LO_LATCH,  // Bus gets PC, PC increments, low target byte latched
        AB_JUMP,      // Bus gets {data byte, low}, PC follows
        AB_HOLD       // Bus repeats last address
    } ab_mode_e;

    typedef enum logic [2:0] {
        ALU_PASS,
        ALU_ADC,
        ALU_INC,
        ALU_NONE      // No result, registers untouched
    } alu_op_e;

    typedef enum logic [1:0] {
        REG_A,
        REG_X,
        REG_DB,       // Data bus as source
        REG_NONE      // Last ALU result as source, nothing as destination
    } reg_sel_e;

    typedef enum logic [2:0] {
        FL_NONE,
        FL_ZN,
        FL_CZN,
        FL_CLC,
        FL_SEC
    } flag_op_e;

    typedef enum logic [7:0] {
        LDA_IMM = 8'hA9,
        LDA_ZP  = 8'hA5,
        LDX_ZP  = 8'hA6,
        STA_ZP  = 8'h85,
        STX_ZP  = 8'h86,
        ADC_IMM = 8'h69,
        CLC     = 8'h18,
        SEC     = 8'h38,
        INX     = 8'hE8,
        JMP_ABS = 8'h4C,
        NOP     = 8'hEA
    } opcode_e;

    typedef struct packed {
        seq_mode_e  seq;      // [31:30]
        ab_mode_e   ab_mode;  // [29:27]
        logic       we_next;  // [26] Write enable for the following cycle
        alu_op_e    alu_op;   // [25:23]
        reg_sel_e   src;      // [22:21]
        reg_sel_e   dst;      // [20:19]
        logic [4:0] finish;   // [18:14] Finisher index
        logic [7:0] link;     // [13:6] Next sequence offset, or flag op in DECODE words
        logic [5:0] spare;    // [5:0] Always zero
    } ucode_t;

    localparam logic [8:0] SEQ_BASE = 9'h100;  // Sequence region
    localparam logic [8:0] FIN_BASE = 9'h140;  // Finisher region

    // Offsets inside the sequence region
    localparam logic [7:0] SQ_FETCH    = 8'd0;
    localparam logic [7:0] SQ_END_NONE = 8'd1;
    localparam logic [7:0] SQ_END_ZN   = 8'd2;
    localparam logic [7:0] SQ_END_CZN  = 8'd3;
    localparam logic [7:0] SQ_END_CLC  = 8'd4;
    localparam logic [7:0] SQ_END_SEC  = 8'd5;
    localparam logic [7:0] SQ_ZP_READ  = 8'd6;
    localparam logic [7:0] SQ_ZP_WRITE = 8'd7;
    localparam logic [7:0] SQ_JMP      = 8'd8;

    // Finisher indices
    localparam logic [4:0] FIN_LDA   = 5'd0;
    localparam logic [4:0] FIN_LDX   = 5'd1;
    localparam logic [4:0] FIN_STORE = 5'd2;

    localparam logic [8:0] FETCH_ADDR = SEQ_BASE + {1'b0, SQ_FETCH};  // Word held in reset

endpackage

// ==== src/micro_rom.sv ====
// Registered 512-word control store holding decode, sequence and finisher micro-words
`timescale 1ns/1ps

module micro_rom (
    input  logic             clk,
    input  logic [8:0]       uaddr,
    output cpu_pkg::ucode_t  word
);

    cpu_pkg::ucode_t rom_data;

    // Builds one micro-word from its fields
    function automatic cpu_pkg::ucode_t uw(
        input cpu_pkg::seq_mode_e seq,
        input cpu_pkg::ab_mode_e  ab_mode,
        input logic               we_next,
        input cpu_pkg::alu_op_e   alu_op,
        input cpu_pkg::reg_sel_e  src,
        input cpu_pkg::reg_sel_e  dst,
        input logic [4:0]         finish,
        input logic [7:0]         link
    );
        cpu_pkg::ucode_t w;
        w.seq     = seq;
        w.ab_mode = ab_mode;
        w.we_next = we_next;
        w.alu_op  = alu_op;
        w.src     = src;
        w.dst     = dst;
        w.finish  = finish;
        w.link    = link;
        w.spare   = 6'd0;
        return w;
    endfunction

    always_comb begin
        case (uaddr)
            // Decode region, one word per opcode
            {1'b0, cpu_pkg::LDA_IMM}: rom_data = uw(cpu_pkg::NEXT, cpu_pkg::AB_PC, 1'b0,
                cpu_pkg::ALU_PASS, cpu_pkg::REG_DB, cpu_pkg::REG_A, 5'd0, cpu_pkg::SQ_END_ZN);
            {1'b0, cpu_pkg::ADC_IMM}: rom_data = uw(cpu_pkg::NEXT, cpu_pkg::AB_PC, 1'b0,
                cpu_pkg::ALU_ADC, cpu_pkg::REG_A, cpu_pkg::REG_A, 5'd0, cpu_pkg::SQ_END_CZN);
            {1'b0, cpu_pkg::LDA_ZP}: rom_data = uw(cpu_pkg::SAVE_FINISH, cpu_pkg::AB_ZP, 1'b0,
                cpu_pkg::ALU_NONE, cpu_pkg::REG_NONE, cpu_pkg::REG_NONE, cpu_pkg::FIN_LDA,
                cpu_pkg::SQ_ZP_READ);
            {1'b0, cpu_pkg::LDX_ZP}: rom_data = uw(cpu_pkg::SAVE_FINISH, cpu_pkg::AB_ZP, 1'b0,
                cpu_pkg::ALU_NONE, cpu_pkg::REG_NONE, cpu_pkg::REG_NONE, cpu_pkg::FIN_LDX,
                cpu_pkg::SQ_ZP_READ);
            {1'b0, cpu_pkg::STA_ZP}: rom_data = uw(cpu_pkg::SAVE_FINISH, cpu_pkg::AB_ZP, 1'b1,
                cpu_pkg::ALU_NONE, cpu_pkg::REG_A, cpu_pkg::REG_NONE, cpu_pkg::FIN_STORE,
                cpu_pkg::SQ_ZP_WRITE);  // A latched onto do_out
            {1'b0, cpu_pkg::STX_ZP}: rom_data = uw(cpu_pkg::SAVE_FINISH, cpu_pkg::AB_ZP, 1'b1,
                cpu_pkg::ALU_NONE, cpu_pkg::REG_X, cpu_pkg::REG_NONE, cpu_pkg::FIN_STORE,
                cpu_pkg::SQ_ZP_WRITE);
            {1'b0, cpu_pkg::CLC}: rom_data = uw(cpu_pkg::NEXT, cpu_pkg::AB_HOLD, 1'b0,
                cpu_pkg::ALU_NONE, cpu_pkg::REG_NONE, cpu_pkg::REG_NONE, 5'd0,
                cpu_pkg::SQ_END_CLC);
            {1'b0, cpu_pkg::SEC}: rom_data = uw(cpu_pkg::NEXT, cpu_pkg::AB_HOLD, 1'b0,
                cpu_pkg::ALU_NONE, cpu_pkg::REG_NONE, cpu_pkg::REG_NONE, 5'd0,
                cpu_pkg::SQ_END_SEC);
            {1'b0, cpu_pkg::INX}: rom_data = uw(cpu_pkg::NEXT, cpu_pkg::AB_HOLD, 1'b0,
                cpu_pkg::ALU_INC, cpu_pkg::REG_X, cpu_pkg::REG_X, 5'd0, cpu_pkg::SQ_END_ZN);
            {1'b0, cpu_pkg::JMP_ABS}: rom_data = uw(cpu_pkg::NEXT, cpu_pkg::AB_LO_LATCH, 1'b0,
                cpu_pkg::ALU_NONE, cpu_pkg::REG_NONE, cpu_pkg::REG_NONE, 5'd0, cpu_pkg::SQ_JMP);

            // Sequence region
            cpu_pkg::FETCH_ADDR: rom_data = uw(cpu_pkg::NEXT, cpu_pkg::AB_PC, 1'b0,
                cpu_pkg::ALU_NONE, cpu_pkg::REG_NONE, cpu_pkg::REG_NONE, 5'd0,
                cpu_pkg::SQ_END_NONE);  // First fetch after reset
            cpu_pkg::SEQ_BASE + 9'(cpu_pkg::SQ_END_NONE): rom_data = uw(cpu_pkg::DECODE,
                cpu_pkg::AB_PC, 1'b0, cpu_pkg::ALU_NONE, cpu_pkg::REG_NONE, cpu_pkg::REG_NONE,
                5'd0, 8'(cpu_pkg::FL_NONE));
            cpu_pkg::SEQ_BASE + 9'(cpu_pkg::SQ_END_ZN): rom_data = uw(cpu_pkg::DECODE,
                cpu_pkg::AB_PC, 1'b0, cpu_pkg::ALU_NONE, cpu_pkg::REG_NONE, cpu_pkg::REG_NONE,
                5'd0, 8'(cpu_pkg::FL_ZN));
            cpu_pkg::SEQ_BASE + 9'(cpu_pkg::SQ_END_CZN): rom_data = uw(cpu_pkg::DECODE,
                cpu_pkg::AB_PC, 1'b0, cpu_pkg::ALU_NONE, cpu_pkg::REG_NONE, cpu_pkg::REG_NONE,
                5'd0, 8'(cpu_pkg::FL_CZN));
            cpu_pkg::SEQ_BASE + 9'(cpu_pkg::SQ_END_CLC): rom_data = uw(cpu_pkg::DECODE,
                cpu_pkg::AB_PC, 1'b0, cpu_pkg::ALU_NONE, cpu_pkg::REG_NONE, cpu_pkg::REG_NONE,
                5'd0, 8'(cpu_pkg::FL_CLC));
            cpu_pkg::SEQ_BASE + 9'(cpu_pkg::SQ_END_SEC): rom_data = uw(cpu_pkg::DECODE,
                cpu_pkg::AB_PC, 1'b0, cpu_pkg::ALU_NONE, cpu_pkg::REG_NONE, cpu_pkg::REG_NONE,
                5'd0, 8'(cpu_pkg::FL_SEC));
            cpu_pkg::SEQ_BASE + 9'(cpu_pkg::SQ_ZP_READ): rom_data = uw(cpu_pkg::FINISH,
                cpu_pkg::AB_PC, 1'b0, cpu_pkg::ALU_PASS, cpu_pkg::REG_DB, cpu_pkg::REG_NONE,
                5'd0, 8'd0);  // Byte parked in the result register
            cpu_pkg::SEQ_BASE + 9'(cpu_pkg::SQ_ZP_WRITE): rom_data = uw(cpu_pkg::FINISH,
                cpu_pkg::AB_HOLD, 1'b0, cpu_pkg::ALU_NONE, cpu_pkg::REG_NONE,
                cpu_pkg::REG_NONE, 5'd0, 8'd0);  // Write cycle, we high
            cpu_pkg::SEQ_BASE + 9'(cpu_pkg::SQ_JMP): rom_data = uw(cpu_pkg::NEXT,
                cpu_pkg::AB_JUMP, 1'b0, cpu_pkg::ALU_NONE, cpu_pkg::REG_NONE, cpu_pkg::REG_NONE,
                5'd0, cpu_pkg::SQ_END_NONE);

            // Finisher region
            cpu_pkg::FIN_BASE + 9'(cpu_pkg::FIN_LDA): rom_data = uw(cpu_pkg::DECODE,
                cpu_pkg::AB_PC, 1'b0, cpu_pkg::ALU_PASS, cpu_pkg::REG_NONE, cpu_pkg::REG_A,
                5'd0, 8'(cpu_pkg::FL_ZN));
            cpu_pkg::FIN_BASE + 9'(cpu_pkg::FIN_LDX): rom_data = uw(cpu_pkg::DECODE,
                cpu_pkg::AB_PC, 1'b0, cpu_pkg::ALU_PASS, cpu_pkg::REG_NONE, cpu_pkg::REG_X,
                5'd0, 8'(cpu_pkg::FL_ZN));
            cpu_pkg::FIN_BASE + 9'(cpu_pkg::FIN_STORE): rom_data = uw(cpu_pkg::NEXT,
                cpu_pkg::AB_PC, 1'b0, cpu_pkg::ALU_NONE, cpu_pkg::REG_NONE, cpu_pkg::REG_NONE,
                5'd0, cpu_pkg::SQ_END_NONE);  // Fetch next opcode after the write

            // Undefined opcodes and unused words behave as NOP
            default: rom_data = uw(cpu_pkg::NEXT, cpu_pkg::AB_HOLD, 1'b0, cpu_pkg::ALU_NONE,
                cpu_pkg::REG_NONE, cpu_pkg::REG_NONE, 5'd0, cpu_pkg::SQ_END_NONE);
        endcase
    end

    always_ff @(posedge clk) begin
        word <= rom_data;  // Synchronous ROM read
    end

endmodule

// ==== src/micro_sequencer.sv ====
// Micro-address FSM: picks the next ROM word, keeps the finisher pointer, flags opcode fetch
`timescale 1ns/1ps

module micro_sequencer (
    input  logic             clk,
    input  logic             reset,
    input  cpu_pkg::ucode_t  word,
    input  logic [7:0]       db_in,
    output logic [8:0]       uaddr,
    output logic             sync
);

    logic [4:0] finish;  // Saved finisher index

    // Next micro-address, registered by the ROM
    always_comb begin
        if (reset) begin
            uaddr = cpu_pkg::FETCH_ADDR;  // Park on fetch word
        end else begin
            case (word.seq)
                cpu_pkg::DECODE:      uaddr = {1'b0, db_in};  // Opcode indexes decode region
                cpu_pkg::NEXT:        uaddr = cpu_pkg::SEQ_BASE + {1'b0, word.link};
                cpu_pkg::SAVE_FINISH: uaddr = cpu_pkg::SEQ_BASE + {1'b0, word.link};
                cpu_pkg::FINISH:      uaddr = cpu_pkg::FIN_BASE + {4'd0, finish};
                default:              uaddr = cpu_pkg::FETCH_ADDR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            finish <= 5'd0;
        end else if (word.seq == cpu_pkg::SAVE_FINISH) begin
            finish <= word.finish;  // Remember where to go after the shared sequence
        end
    end

    // Opcode is on db_in whenever a DECODE word is active
    assign sync = (word.seq == cpu_pkg::DECODE);

endmodule
